// File: common/bip_cfg.svh
`ifndef BIP_CFG_SVH
`define BIP_CFG_SVH

// Word and field widths
`define BIP_NB_BITS    16
`define BIP_NB_OPC     5
`define BIP_NB_SIGX    11    // Immediate field, sign bit included

// Program memory
`define BIP_INS_DEPTH  2048
`define BIP_NB_INS     11

// Data memory
`define BIP_DTA_DEPTH  1024
`define BIP_NB_DTA     10

`endif

// File: common/bip_isa_pkg.sv
`include "bip_cfg.svh"
`default_nettype none

package bip_isa_pkg;

   typedef enum logic [`BIP_NB_OPC-1:0] {
      OPC_HALT = 5'd0,
      OPC_STO  = 5'd1,   // Store variable
      OPC_LD   = 5'd2,   // Load variable
      OPC_LDI  = 5'd3,   // Load immediate
      OPC_ADD  = 5'd4,
      OPC_ADDI = 5'd5,
      OPC_SUB  = 5'd6,
      OPC_SUBI = 5'd7
   } bip_opcode_e;

   // Variable instructions address data memory
   typedef struct packed {
      bip_opcode_e                                       opcode;
      logic [`BIP_NB_BITS-`BIP_NB_OPC-`BIP_NB_DTA-1:0]   unused;
      logic [`BIP_NB_DTA-1:0]                            addr;
   } bip_ins_var_s;

   // Immediate instructions carry a two's-complement operand
   typedef struct packed {
      bip_opcode_e                    opcode;
      logic signed [`BIP_NB_SIGX-1:0] imm;
   } bip_ins_imm_s;

   typedef union packed {
      bip_ins_var_s var_f;
      bip_ins_imm_s imm_f;
   } bip_instr_u;

endpackage

`default_nettype wire

// File: common/bip_ctrl_pkg.sv
`default_nettype none

package bip_ctrl_pkg;

   // Accumulator load source
   typedef enum logic [1:0] {
      SRC_MEM  = 2'd0,
      SRC_IMM  = 2'd1,
      SRC_ALU  = 2'd2,
      SRC_NONE = 2'd3
   } bip_acc_src_e;

   typedef struct packed {
      bip_acc_src_e sel_a;
      logic         sel_b;    // 1 takes the immediate
      logic         wr_acc;
      logic         op_add;   // 0 subtracts
      logic         wr;       // Data memory write strobe
      logic         rd;       // Data memory read strobe
   } bip_ctrl_s;

endpackage

`default_nettype wire

// File: hdl/bip_control.sv
`include "bip_cfg.svh"
`default_nettype none

module bip_control
   import bip_isa_pkg::*, bip_ctrl_pkg::*;
(
   input  wire logic                   i_clk,
   input  wire logic                   i_rst,
   input  wire logic                   i_run,
   input  wire bip_instr_u             i_instr,
   output logic [`BIP_NB_INS-1:0]      o_pc,
   output bip_ctrl_s                   o_ctrl,
   output logic                        o_halted
);

   logic [`BIP_NB_INS-1:0] pc_q;
   logic                   run_q;      // i_run delayed for edge detect
   logic                   running_q;
   logic                   halted_q;
   logic                   start;
   logic                   adv_pc;
   bip_ctrl_s              ctrl_dec;

   assign start = i_run & ~run_q;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         pc_q      <= '0;
         run_q     <= 1'b0;
         running_q <= 1'b0;
         halted_q  <= 1'b0;
      end else begin
         run_q <= i_run;
         if (start) begin
            pc_q      <= '0;
            running_q <= 1'b1;
            halted_q  <= 1'b0;
         end else if (running_q) begin
            if (adv_pc) begin
               pc_q <= pc_q + 1'b1;
            end else begin
               running_q <= 1'b0;       // pc stays on the halt
               halted_q  <= 1'b1;
            end
         end else if (!i_run) begin
            halted_q <= 1'b0;
         end
      end
   end

   always_comb begin
      ctrl_dec = '0;
      adv_pc   = 1'b1;
      case (i_instr.var_f.opcode)
         OPC_STO: begin
            ctrl_dec.sel_a = SRC_NONE;
            ctrl_dec.wr    = 1'b1;
         end
         OPC_LD: begin
            ctrl_dec.sel_a  = SRC_MEM;
            ctrl_dec.wr_acc = 1'b1;
            ctrl_dec.rd     = 1'b1;
         end
         OPC_LDI: begin
            ctrl_dec.sel_a  = SRC_IMM;
            ctrl_dec.wr_acc = 1'b1;
         end
         OPC_ADD: begin
            ctrl_dec.sel_a  = SRC_ALU;
            ctrl_dec.wr_acc = 1'b1;
            ctrl_dec.op_add = 1'b1;
            ctrl_dec.rd     = 1'b1;
         end
         OPC_ADDI: begin
            ctrl_dec.sel_a  = SRC_ALU;
            ctrl_dec.sel_b  = 1'b1;
            ctrl_dec.wr_acc = 1'b1;
            ctrl_dec.op_add = 1'b1;
         end
         OPC_SUB: begin
            ctrl_dec.sel_a  = SRC_ALU;
            ctrl_dec.wr_acc = 1'b1;
            ctrl_dec.rd     = 1'b1;
         end
         OPC_SUBI: begin
            ctrl_dec.sel_a  = SRC_ALU;
            ctrl_dec.sel_b  = 1'b1;
            ctrl_dec.wr_acc = 1'b1;
         end
         default: begin
            adv_pc = 1'b0;             // Halt and undefined opcodes
         end
      endcase
   end

   assign o_ctrl   = running_q ? ctrl_dec : '0;
   assign o_pc     = pc_q;
   assign o_halted = halted_q;

endmodule

`default_nettype wire

// File: hdl/bip_program_mem.sv
`include "bip_cfg.svh"
`default_nettype none

module bip_program_mem
   import bip_isa_pkg::*;
(
   input  wire logic                   i_clk,
   input  wire logic                   i_we,
   input  wire logic [`BIP_NB_INS-1:0] i_waddr,
   input  wire bip_instr_u             i_wdata,
   input  wire logic [`BIP_NB_INS-1:0] i_raddr,
   output bip_instr_u                  o_rdata
);

   bip_instr_u mem [`BIP_INS_DEPTH];

   // Empty words decode as halt
   initial begin
      for (int i = 0; i < `BIP_INS_DEPTH; i++) begin
         mem[i] = '0;
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_we) begin
         mem[i_waddr] <= i_wdata;
      end
   end

   assign o_rdata = mem[i_raddr];    // Fetch within the cycle

endmodule

`default_nettype wire

// File: hdl/bip_data_mem.sv
`include "bip_cfg.svh"
`default_nettype none

module bip_data_mem (
   input  wire logic                    i_clk,
   input  wire logic                    i_wr,
   input  wire logic                    i_rd,
   input  wire logic [`BIP_NB_DTA-1:0]  i_addr,
   input  wire logic [`BIP_NB_BITS-1:0] i_wdata,
   output logic [`BIP_NB_BITS-1:0]      o_rdata
);

   logic [`BIP_NB_BITS-1:0] mem [`BIP_DTA_DEPTH];

   initial begin
      for (int i = 0; i < `BIP_DTA_DEPTH; i++) begin
         mem[i] = '0;                // Unwritten variables read zero
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_wr) begin
         mem[i_addr] <= i_wdata;
      end
   end

   assign o_rdata = i_rd ? mem[i_addr] : '0;   // Quiet bus when idle

endmodule

`default_nettype wire

// File: datapath/bip_datapath.sv
`include "bip_cfg.svh"
`default_nettype none

module bip_datapath
   import bip_isa_pkg::*, bip_ctrl_pkg::*;
(
   input  wire logic                    i_clk,
   input  wire logic                    i_rst,
   input  wire bip_instr_u              i_instr,
   input  wire bip_ctrl_s               i_ctrl,
   input  wire logic [`BIP_NB_BITS-1:0] i_mem_rdata,
   output logic [`BIP_NB_BITS-1:0]      o_acc
);

   logic [`BIP_NB_BITS-1:0] acc_q;
   logic [`BIP_NB_BITS-1:0] imm_ext;
   logic [`BIP_NB_BITS-1:0] operand;
   logic [`BIP_NB_BITS-1:0] alu_res;

   // Sign extension of the immediate field
   assign imm_ext = {{(`BIP_NB_BITS-`BIP_NB_SIGX){i_instr.imm_f.imm[`BIP_NB_SIGX-1]}},
                     i_instr.imm_f.imm};

   assign operand = i_ctrl.sel_b ? imm_ext : i_mem_rdata;

   // Wraps modulo 2^16
   assign alu_res = i_ctrl.op_add ? acc_q + operand : acc_q - operand;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         acc_q <= '0;
      end else if (i_ctrl.wr_acc) begin
         case (i_ctrl.sel_a)
            SRC_MEM: acc_q <= i_mem_rdata;
            SRC_IMM: acc_q <= imm_ext;
            SRC_ALU: acc_q <= alu_res;
            default: acc_q <= acc_q;  // SRC_NONE keeps the value
         endcase
      end
   end

   assign o_acc = acc_q;

endmodule

`default_nettype wire

// File: hdl/bip_top.sv
`include "bip_cfg.svh"
`default_nettype none

module bip_top
   import bip_isa_pkg::*, bip_ctrl_pkg::*;
(
   input  wire logic                   i_clk,
   input  wire logic                   i_rst,
   input  wire logic                   i_run,
   input  wire logic                   i_prog_we,
   input  wire logic [`BIP_NB_INS-1:0] i_prog_addr,
   input  wire bip_instr_u             i_prog_data,
   output logic [`BIP_NB_BITS-1:0]     o_acc,
   output logic [`BIP_NB_INS-1:0]      o_pc,
   output logic                        o_halted
);

   bip_instr_u              instr;
   bip_ctrl_s               ctrl;
   logic [`BIP_NB_BITS-1:0] dmem_rdata;

   bip_control bip_control_i (
      .i_clk    (i_clk),
      .i_rst    (i_rst),
      .i_run    (i_run),
      .i_instr  (instr),
      .o_pc     (o_pc),
      .o_ctrl   (ctrl),
      .o_halted (o_halted)
   );

   bip_program_mem bip_program_mem_i (
      .i_clk   (i_clk),
      .i_we    (i_prog_we),
      .i_waddr (i_prog_addr),
      .i_wdata (i_prog_data),
      .i_raddr (o_pc),
      .o_rdata (instr)
   );

   bip_data_mem bip_data_mem_i (
      .i_clk   (i_clk),
      .i_wr    (ctrl.wr),
      .i_rd    (ctrl.rd),
      .i_addr  (instr.var_f.addr),    // Variable view of the word
      .i_wdata (o_acc),
      .o_rdata (dmem_rdata)
   );

   bip_datapath bip_datapath_i (
      .i_clk       (i_clk),
      .i_rst       (i_rst),
      .i_instr     (instr),
      .i_ctrl      (ctrl),
      .i_mem_rdata (dmem_rdata),
      .o_acc       (o_acc)
   );

endmodule

`default_nettype wire

// File: tests/bip_clk_gen.sv
`default_nettype none

module bip_clk_gen (
   output logic o_clk,
   output logic o_rst
);

   initial begin
      o_clk = 1'b0;
      forever begin
         #5 o_clk = ~o_clk;          // Period of 10
      end
   end

   initial begin
      o_rst = 1'b1;
      repeat (2) @(posedge o_clk);
      #1;
      o_rst = 1'b0;
   end

endmodule

`default_nettype wire

// File: tests/bip_assertions.sv
`include "bip_cfg.svh"
`default_nettype none

module bip_assertions
   import bip_ctrl_pkg::*;
(
   input  wire logic                   i_clk,
   input  wire logic                   i_rst,
   input  wire logic                   i_run,
   input  wire logic [`BIP_NB_INS-1:0] i_pc,
   input  wire bip_ctrl_s              i_ctrl,
   input  wire logic                   i_halted
);

   wr_rd_exclusive: assert property (@(posedge i_clk) disable iff (i_rst)
      !(i_ctrl.wr && i_ctrl.rd))
      else $error("data memory read and write strobes high together");

   // A restart clears halted at the same edge that clears pc
   pc_held: assert property (@(posedge i_clk) disable iff (i_rst)
      ($past(i_halted) && i_halted) |-> $stable(i_pc))
      else $error("program counter moved while halted");

   // Stopped means halted or run low
   idle_ctrl_zero: assert property (@(posedge i_clk) disable iff (i_rst)
      (i_halted || !i_run) |-> (i_ctrl == '0))
      else $error("control word not zero while stopped");

endmodule

bind bip_control bip_assertions bip_assertions_i (
   .i_clk    (i_clk),
   .i_rst    (i_rst),
   .i_run    (i_run),
   .i_pc     (o_pc),
   .i_ctrl   (o_ctrl),
   .i_halted (o_halted)
);

`default_nettype wire

// File: tests/bip_tb.sv
`include "bip_cfg.svh"
`default_nettype none

module bip_tb
   import bip_isa_pkg::*;
();

   localparam bip_instr_u halt_word  = '0;
   localparam bip_instr_u undef_word = {5'd9, 11'd0};

   logic                    clk;
   logic                    rst;
   logic                    run;
   logic                    prog_we;
   logic [`BIP_NB_INS-1:0]  prog_addr;
   bip_instr_u              prog_data;
   logic [`BIP_NB_BITS-1:0] acc;
   logic [`BIP_NB_INS-1:0]  pc;
   logic                    halted;

   bip_instr_u              prog [$];
   logic [`BIP_NB_BITS-1:0] model_acc;                   // Survives across tests
   logic [`BIP_NB_BITS-1:0] model_mem [`BIP_DTA_DEPTH];

   string                   test_name;
   logic [`BIP_NB_BITS-1:0] exp_acc;
   logic [`BIP_NB_INS-1:0]  exp_pc;
   bit                      check_req;
   bit                      check_done;
   bit                      aborted;
   int                      tests_passed;
   int                      tests_failed;

   bip_clk_gen bip_clk_gen_i (
      .o_clk (clk),
      .o_rst (rst)
   );

   bip_top bip_top_i (
      .i_clk       (clk),
      .i_rst       (rst),
      .i_run       (run),
      .i_prog_we   (prog_we),
      .i_prog_addr (prog_addr),
      .i_prog_data (prog_data),
      .o_acc       (acc),
      .o_pc        (pc),
      .o_halted    (halted)
   );

   task automatic tick();
      @(posedge clk);
      #1;
   endtask

   function automatic bip_instr_u imm_word(input bip_opcode_e op, input int value);
      bip_instr_u w;
      w.imm_f.opcode = op;
      w.imm_f.imm    = value[`BIP_NB_SIGX-1:0];
      return w;
   endfunction

   function automatic bip_instr_u var_word(input bip_opcode_e op, input int addr);
      bip_instr_u w;
      w = '0;
      w.var_f.opcode = op;
      w.var_f.addr   = addr[`BIP_NB_DTA-1:0];
      return w;
   endfunction

   function automatic bip_instr_u random_word();
      logic [`BIP_NB_BITS-1:0] raw;
      logic [`BIP_NB_OPC-1:0]  opc;
      bip_instr_u              w;
      raw = $urandom;
      w   = raw;
      if ($urandom_range(31, 0) == 0) begin
         opc = 5'd0;
      end else begin
         opc = $urandom_range(7, 1);
      end
      w.var_f.opcode = bip_opcode_e'(opc);
      if (opc inside {OPC_STO, OPC_LD, OPC_ADD, OPC_SUB}) begin
         w.var_f.addr = $urandom_range(31, 0);   // Small window so stores get reused
      end
      return w;
   endfunction

   // Interprets prog from pc 0 over the model state
   function automatic void reference_run(output logic [`BIP_NB_INS-1:0] end_pc,
                                         output logic [`BIP_NB_BITS-1:0] end_acc);
      int                      pc_m;
      bit                      done;
      logic [`BIP_NB_BITS-1:0] imm;
      logic [`BIP_NB_DTA-1:0]  addr;
      pc_m = 0;
      done = 1'b0;
      while (!done && pc_m < prog.size()) begin
         imm  = $signed(prog[pc_m].imm_f.imm);   // Two's complement operand
         addr = prog[pc_m].var_f.addr;
         case (prog[pc_m].var_f.opcode)
            OPC_STO:  model_mem[addr] = model_acc;
            OPC_LD:   model_acc = model_mem[addr];
            OPC_LDI:  model_acc = imm;
            OPC_ADD:  model_acc = model_acc + model_mem[addr];
            OPC_ADDI: model_acc = model_acc + imm;
            OPC_SUB:  model_acc = model_acc - model_mem[addr];
            OPC_SUBI: model_acc = model_acc - imm;
            default:  done = 1'b1;           // Halt or undefined
         endcase
         if (!done) begin
            pc_m++;
         end
      end
      end_pc  = pc_m;
      end_acc = model_acc;
   endfunction

   task automatic load_program();
      for (int i = 0; i < prog.size(); i++) begin
         prog_we   = 1'b1;
         prog_addr = i;
         prog_data = prog[i];
         tick();
      end
      prog_we = 1'b0;
   endtask

   task automatic wait_for_halted(input logic level, input int limit, output bit ok);
      int n;
      n = 0;
      while (halted !== level && n < limit) begin
         tick();
         n++;
      end
      ok = (halted === level);
   endtask

   task automatic run_test(input string name);
      logic [`BIP_NB_INS-1:0]  end_pc;
      logic [`BIP_NB_BITS-1:0] end_acc;
      bit                      ok;
      int                      n;
      if (!aborted) begin
         load_program();
         reference_run(end_pc, end_acc);
         run = 1'b1;
         wait_for_halted(1'b1, prog.size() + 10, ok);
         if (!ok) begin
            $display("ERROR: test %s never reached halt", name);
            tests_failed++;
            aborted = 1'b1;
         end else begin
            test_name  = name;
            exp_acc    = end_acc;
            exp_pc     = end_pc;
            check_done = 1'b0;
            check_req  = 1'b1;
            n = 0;
            while (!check_done && n < 4) begin
               tick();
               n++;
            end
            if (!check_done) begin
               $display("ERROR: test %s was never compared", name);
               tests_failed++;
               aborted = 1'b1;
            end
         end
         run = 1'b0;
         wait_for_halted(1'b0, 4, ok);
         if (!ok && !aborted) begin
            $display("ERROR: halted flag stayed high after run dropped in %s", name);
            tests_failed++;
            aborted = 1'b1;
         end
      end
   endtask

   always @(negedge clk) begin
      int errs;
      if (check_req) begin
         errs = 0;
         assert (acc === exp_acc) else begin
            $display("CHECK FAILED %s: o_acc expected %h actual %h", test_name, exp_acc, acc);
            errs++;
         end
         assert (pc === exp_pc) else begin
            $display("CHECK FAILED %s: o_pc expected %0d actual %0d", test_name, exp_pc, pc);
            errs++;
         end
         if (errs == 0) begin
            tests_passed++;
            $display("test %-12s ok     acc %h pc %0d", test_name, acc, pc);
         end else begin
            tests_failed++;
            $display("test %-12s failed", test_name);
         end
         check_req  = 1'b0;
         check_done = 1'b1;
      end
   end

   initial begin
      int seed_ret;
      int n;
      int len;
      run          = 1'b0;
      prog_we      = 1'b0;
      prog_addr    = '0;
      prog_data    = '0;
      check_req    = 1'b0;
      check_done   = 1'b0;
      aborted      = 1'b0;
      tests_passed = 0;
      tests_failed = 0;
      model_acc    = '0;
      for (int i = 0; i < `BIP_DTA_DEPTH; i++) begin
         model_mem[i] = '0;
      end
      seed_ret = $urandom(32'h5c06_9591);
      n = 0;
      while (rst !== 1'b0 && n < 10) begin
         tick();
         n++;
      end
      if (rst !== 1'b0) begin
         $display("ERROR: reset was never released");
         aborted = 1'b1;
      end

      prog = '{imm_word(OPC_LDI, -300), halt_word};
      run_test("ldi_halt");

      // LDI -1 then ADDI 5 wraps 0xffff to 4
      prog = '{imm_word(OPC_LDI, 1000), imm_word(OPC_ADDI, 1023),
               imm_word(OPC_SUBI, -1024), imm_word(OPC_ADDI, -1024),
               imm_word(OPC_LDI, -1), imm_word(OPC_ADDI, 5),
               imm_word(OPC_SUBI, 7), imm_word(OPC_SUBI, 1023), halt_word};
      run_test("imm_arith");

      prog = '{imm_word(OPC_LDI, 111), var_word(OPC_STO, 3),
               imm_word(OPC_LDI, -222), var_word(OPC_STO, 700),
               imm_word(OPC_LDI, 333), var_word(OPC_STO, 1023),
               imm_word(OPC_LDI, 0), var_word(OPC_LD, 1023),
               var_word(OPC_LD, 3), var_word(OPC_LD, 700), halt_word};
      run_test("store_load");

      // Addresses 998 and 999 are never written
      prog = '{imm_word(OPC_LDI, 50), var_word(OPC_ADD, 3),
               var_word(OPC_SUB, 700), var_word(OPC_ADD, 1023),
               var_word(OPC_STO, 10), var_word(OPC_LD, 999),
               var_word(OPC_ADD, 10), var_word(OPC_ADD, 10),
               var_word(OPC_SUB, 998), halt_word};
      run_test("var_arith");

      prog = '{imm_word(OPC_LDI, 77), imm_word(OPC_ADDI, 3), undef_word,
               imm_word(OPC_ADDI, 100), halt_word};
      run_test("undef_opcode");

      for (int t = 0; t < 20; t++) begin
         len = $urandom_range(39, 1);
         prog.delete();
         for (int i = 0; i < len; i++) begin
            prog.push_back(random_word());
         end
         prog.push_back(halt_word);
         run_test($sformatf("random_%0d", t));
      end

      $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
      if (tests_failed == 0 && !aborted) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: flist.f
+incdir+common
common/bip_isa_pkg.sv
common/bip_ctrl_pkg.sv
hdl/bip_control.sv
hdl/bip_program_mem.sv
hdl/bip_data_mem.sv
datapath/bip_datapath.sv
hdl/bip_top.sv
tests/bip_clk_gen.sv
tests/bip_assertions.sv
tests/bip_tb.sv
